// File: design/hazardPkg.sv
package hazardPkg;

	////////////////////////////////////////////////////////////////////
	// Instruction word, R and I views over the same 32 bits
	////////////////////////////////////////////////////////////////////
	typedef union packed {
		struct packed {
			logic [5:0] op;
			logic [4:0] rs;
			logic [4:0] rt;
			logic [4:0] rd;
			logic [4:0] shamt;
			logic [5:0] funct;
		} r;
		struct packed {
			logic [5:0]  op;
			logic [4:0]  rs;
			logic [4:0]  rt; // REGIMM selector lives here
			logic [15:0] imm;
		} i;
	} instrWord_t;

	////////////////////////////////////////////////////////////////////
	// Instruction classes
	////////////////////////////////////////////////////////////////////
	localparam logic [3:0] CLS_NONE   = 4'd0;
	localparam logic [3:0] CLS_ALUR   = 4'd1;
	localparam logic [3:0] CLS_ALUI   = 4'd2;
	localparam logic [3:0] CLS_LOAD   = 4'd3;
	localparam logic [3:0] CLS_STORE  = 4'd4;
	localparam logic [3:0] CLS_BR1    = 4'd5;  // bgez bgtz blez bltz
	localparam logic [3:0] CLS_BR2    = 4'd6;  // beq bne
	localparam logic [3:0] CLS_LUI    = 4'd7;
	localparam logic [3:0] CLS_JAL    = 4'd8;
	localparam logic [3:0] CLS_JR     = 4'd9;
	localparam logic [3:0] CLS_J      = 4'd10;
	localparam logic [3:0] CLS_JALR   = 4'd11;
	localparam logic [3:0] CLS_MTMD   = 4'd12; // mthi mtlo
	localparam logic [3:0] CLS_MULDIV = 4'd13;
	localparam logic [3:0] CLS_MFMD   = 4'd14; // mfhi mflo

	// Primary opcodes
	localparam logic [5:0] OP_SPECIAL = 6'b000000;
	localparam logic [5:0] OP_REGIMM  = 6'b000001;
	localparam logic [5:0] OP_J       = 6'b000010;
	localparam logic [5:0] OP_JAL     = 6'b000011;
	localparam logic [5:0] OP_BEQ     = 6'b000100;
	localparam logic [5:0] OP_BNE     = 6'b000101;
	localparam logic [5:0] OP_BLEZ    = 6'b000110;
	localparam logic [5:0] OP_BGTZ    = 6'b000111;
	localparam logic [5:0] OP_ADDI    = 6'b001000;
	localparam logic [5:0] OP_ADDIU   = 6'b001001;
	localparam logic [5:0] OP_SLTI    = 6'b001010;
	localparam logic [5:0] OP_SLTIU   = 6'b001011;
	localparam logic [5:0] OP_ANDI    = 6'b001100;
	localparam logic [5:0] OP_ORI     = 6'b001101;
	localparam logic [5:0] OP_XORI    = 6'b001110;
	localparam logic [5:0] OP_LUI     = 6'b001111;
	localparam logic [5:0] OP_LB      = 6'b100000;
	localparam logic [5:0] OP_LH      = 6'b100001;
	localparam logic [5:0] OP_LW      = 6'b100011;
	localparam logic [5:0] OP_LBU     = 6'b100100;
	localparam logic [5:0] OP_LHU     = 6'b100101;
	localparam logic [5:0] OP_SB      = 6'b101000;
	localparam logic [5:0] OP_SH      = 6'b101001;
	localparam logic [5:0] OP_SW      = 6'b101011;

	// REGIMM rt selectors
	localparam logic [4:0] RT_BLTZ = 5'b00000;
	localparam logic [4:0] RT_BGEZ = 5'b00001;

	// SPECIAL funct codes
	localparam logic [5:0] FN_SLL   = 6'b000000;
	localparam logic [5:0] FN_SRL   = 6'b000010;
	localparam logic [5:0] FN_SRA   = 6'b000011;
	localparam logic [5:0] FN_SLLV  = 6'b000100;
	localparam logic [5:0] FN_SRLV  = 6'b000110;
	localparam logic [5:0] FN_SRAV  = 6'b000111;
	localparam logic [5:0] FN_JR    = 6'b001000;
	localparam logic [5:0] FN_JALR  = 6'b001001;
	localparam logic [5:0] FN_MFHI  = 6'b010000;
	localparam logic [5:0] FN_MTHI  = 6'b010001;
	localparam logic [5:0] FN_MFLO  = 6'b010010;
	localparam logic [5:0] FN_MTLO  = 6'b010011;
	localparam logic [5:0] FN_MULT  = 6'b011000;
	localparam logic [5:0] FN_MULTU = 6'b011001;
	localparam logic [5:0] FN_DIV   = 6'b011010;
	localparam logic [5:0] FN_DIVU  = 6'b011011;
	localparam logic [5:0] FN_ADD   = 6'b100000;
	localparam logic [5:0] FN_ADDU  = 6'b100001;
	localparam logic [5:0] FN_SUB   = 6'b100010;
	localparam logic [5:0] FN_SUBU  = 6'b100011;
	localparam logic [5:0] FN_AND   = 6'b100100;
	localparam logic [5:0] FN_OR    = 6'b100101;
	localparam logic [5:0] FN_XOR   = 6'b100110;
	localparam logic [5:0] FN_NOR   = 6'b100111;
	localparam logic [5:0] FN_SLT   = 6'b101010;
	localparam logic [5:0] FN_SLTU  = 6'b101011;

	////////////////////////////////////////////////////////////////////
	// Timing figures, stages counted from D
	////////////////////////////////////////////////////////////////////
	localparam logic [2:0] TUSE_D    = 3'd0; // Branch/jump compare in D
	localparam logic [2:0] TUSE_E    = 3'd1; // ALU operand
	localparam logic [2:0] TUSE_M    = 3'd2; // Store data
	localparam logic [2:0] TUSE_NONE = 3'd7; // Operand not read

	localparam logic [2:0] TNEW_NONE = 3'd0; // No register write
	localparam logic [2:0] TNEW_LINK = 3'd1; // lui, jal, jalr
	localparam logic [2:0] TNEW_ALU  = 3'd2; // ALU and mfhi/mflo
	localparam logic [2:0] TNEW_LOAD = 3'd3;

	// Forwarding source select
	localparam logic [1:0] FWD_RF = 2'd0;
	localparam logic [1:0] FWD_E  = 2'd1;
	localparam logic [1:0] FWD_M  = 2'd2;
	localparam logic [1:0] FWD_W  = 2'd3;

	localparam logic [4:0] REG_RA = 5'd31; // Link register

endpackage

// File: design/atIf.sv
`timescale 1ns/1ps

// Register needs and result timing of the instruction sitting in D
interface atIf;
	logic [4:0] raddr0; // rs side
	logic [4:0] raddr1; // rt side
	logic [4:0] waddr;  // 0 when nothing is written
	logic [2:0] tuse0;
	logic [2:0] tuse1;
	logic [2:0] tnew;

	modport producer (
		output raddr0,
		output raddr1,
		output waddr,
		output tuse0,
		output tuse1,
		output tnew
	);

	modport consumer (
		input raddr0,
		input raddr1,
		input waddr,
		input tuse0,
		input tuse1,
		input tnew
	);
endinterface

// File: design/instrDecode.sv
`timescale 1ns/1ps

module instrDecode (
	input  hazardPkg::instrWord_t instr,
	output logic [3:0]            cls
);
	import hazardPkg::*;

	always_comb
	begin
		cls = CLS_NONE; // Unknown opcodes fall through here
		if (instr == '0)
		begin
			cls = CLS_NONE; // nop, sll $0,$0,0
		end
		else
		begin
			case (instr.r.op)
				OP_SPECIAL:
					case (instr.r.funct)
						FN_ADDU, FN_SUBU, FN_ADD, FN_SUB,
						FN_AND, FN_OR, FN_XOR, FN_NOR,
						FN_SLL, FN_SRL, FN_SRA,
						FN_SLLV, FN_SRLV, FN_SRAV,
						FN_SLT, FN_SLTU:
							cls = CLS_ALUR;
						FN_JR:   cls = CLS_JR;
						FN_JALR: cls = CLS_JALR;
						FN_MTHI, FN_MTLO:
							cls = CLS_MTMD;
						FN_MULT, FN_MULTU, FN_DIV, FN_DIVU:
							cls = CLS_MULDIV;
						FN_MFHI, FN_MFLO:
							cls = CLS_MFMD;
						default: cls = CLS_NONE;
					endcase
				OP_REGIMM:
					// Only the two plain compares, no link variants
					case (instr.i.rt)
						RT_BLTZ, RT_BGEZ: cls = CLS_BR1;
						default:          cls = CLS_NONE;
					endcase
				OP_ADDI, OP_ADDIU, OP_SLTI, OP_SLTIU,
				OP_ANDI, OP_ORI, OP_XORI:
					cls = CLS_ALUI;
				OP_LB, OP_LH, OP_LW, OP_LBU, OP_LHU:
					cls = CLS_LOAD;
				OP_SB, OP_SH, OP_SW:
					cls = CLS_STORE;
				OP_BLEZ, OP_BGTZ: cls = CLS_BR1; // rt field ignored
				OP_BEQ, OP_BNE:   cls = CLS_BR2;
				OP_LUI:           cls = CLS_LUI;
				OP_JAL:           cls = CLS_JAL;
				OP_J:             cls = CLS_J;
				default:          cls = CLS_NONE;
			endcase
		end
	end

endmodule

// File: design/atCalc.sv
`timescale 1ns/1ps

module atCalc (
	input  logic [3:0]            cls,
	input  hazardPkg::instrWord_t instr,
	atIf.producer                 at
);
	import hazardPkg::*;

	////////////////////////////////////////////////////////////////////
	// Per-class table of operands, destination and timing
	////////////////////////////////////////////////////////////////////
	always_comb
	begin
		// Defaults describe an instruction touching no register
		at.raddr0 = 5'd0;
		at.raddr1 = 5'd0;
		at.waddr  = 5'd0;
		at.tuse0  = TUSE_NONE;
		at.tuse1  = TUSE_NONE;
		at.tnew   = TNEW_NONE;
		case (cls)
			CLS_ALUR:
			begin
				at.raddr0 = instr.r.rs;
				at.raddr1 = instr.r.rt;
				at.waddr  = instr.r.rd;
				at.tuse0  = TUSE_E;
				at.tuse1  = TUSE_E;
				at.tnew   = TNEW_ALU; // Result leaves E
			end
			CLS_ALUI, CLS_LOAD:
			begin
				at.raddr0 = instr.r.rs; // Base or ALU operand
				at.waddr  = instr.r.rt;
				at.tuse0  = TUSE_E;
				at.tnew   = (cls == CLS_LOAD) ? TNEW_LOAD : TNEW_ALU;
			end
			CLS_STORE:
			begin
				at.raddr0 = instr.r.rs;
				at.raddr1 = instr.r.rt;
				at.tuse0  = TUSE_E; // Address calc
				at.tuse1  = TUSE_M; // Data only needed in M
			end
			CLS_BR1, CLS_JR:
			begin
				at.raddr0 = instr.r.rs;
				at.tuse0  = TUSE_D; // Resolved in D
			end
			CLS_BR2:
			begin
				at.raddr0 = instr.r.rs;
				at.raddr1 = instr.r.rt;
				at.tuse0  = TUSE_D;
				at.tuse1  = TUSE_D;
			end
			CLS_LUI:
			begin
				at.waddr = instr.r.rt;
				at.tnew  = TNEW_LINK; // Value ready from the immediate
			end
			CLS_JAL:
			begin
				at.waddr = REG_RA;
				at.tnew  = TNEW_LINK; // PC+8 known in D
			end
			CLS_JALR:
			begin
				at.raddr0 = instr.r.rs;
				at.waddr  = instr.r.rd;
				at.tuse0  = TUSE_D;
				at.tnew   = TNEW_LINK;
			end
			CLS_MTMD:
			begin
				at.raddr0 = instr.r.rs;
				at.tuse0  = TUSE_E;
			end
			CLS_MULDIV:
			begin
				at.raddr0 = instr.r.rs;
				at.raddr1 = instr.r.rt;
				at.tuse0  = TUSE_E; // Both operands enter the unit in E
				at.tuse1  = TUSE_E;
			end
			CLS_MFMD:
			begin
				at.waddr = instr.r.rd;
				at.tnew  = TNEW_ALU; // HI/LO read in E
			end
			default:
			begin
				at.tnew = TNEW_NONE; // CLS_NONE and j keep the defaults
			end
		endcase
	end

endmodule

// File: design/atPipe.sv
`timescale 1ns/1ps

module atPipe (
	input  logic       clk,
	input  logic       rst,
	input  logic       stall,
	atIf.consumer      at,
	output logic [4:0] eWaddr,
	output logic [2:0] eTnew,
	output logic [4:0] mWaddr,
	output logic [2:0] mTnew,
	output logic [4:0] wWaddr
);
	import hazardPkg::*;

	// One stage closer to the result, never below zero
	function automatic logic [2:0] decTnew(input logic [2:0] t);
		logic [2:0] res;
		if (t == TNEW_NONE)
			res = TNEW_NONE;
		else
			res = t - 3'd1;
		return res;
	endfunction

	////////////////////////////////////////////////////////////////////
	// E stage, takes a bubble while D is held
	////////////////////////////////////////////////////////////////////
	always_ff @(posedge clk)
	begin
		if (rst)
		begin
			eWaddr <= 5'd0;
			eTnew  <= TNEW_NONE;
		end
		else if (stall)
		begin
			eWaddr <= 5'd0; // Bubble writes nothing
			eTnew  <= TNEW_NONE;
		end
		else
		begin
			eWaddr <= at.waddr;
			eTnew  <= decTnew(at.tnew);
		end
	end

	////////////////////////////////////////////////////////////////////
	// M and W stages, never held
	////////////////////////////////////////////////////////////////////
	always_ff @(posedge clk)
	begin
		if (rst)
		begin
			mWaddr <= 5'd0;
			mTnew  <= TNEW_NONE;
			wWaddr <= 5'd0;
		end
		else
		begin
			mWaddr <= eWaddr;
			mTnew  <= decTnew(eTnew);
			wWaddr <= mWaddr; // Tnew is always 0 by W
		end
	end

endmodule

// File: design/stallCtrl.sv
`timescale 1ns/1ps

module stallCtrl (
	atIf.consumer      at,
	input  logic [4:0] eWaddr,
	input  logic [2:0] eTnew,
	input  logic [4:0] mWaddr,
	input  logic [2:0] mTnew,
	input  logic [4:0] wWaddr,
	output logic       stall,
	output logic [1:0] fwdRs,
	output logic [1:0] fwdRt
);
	import hazardPkg::*;

	logic stallRs;
	logic stallRt;

	// Producer in E or M not ready before this operand is consumed
	// Tuse of 7 exceeds any Tnew, so unused operands drop out here
	function automatic logic needStall(
		input logic [4:0] raddr,
		input logic [2:0] tuse,
		input logic [4:0] eAddr,
		input logic [2:0] eT,
		input logic [4:0] mAddr,
		input logic [2:0] mT
	);
		logic hitE;
		logic hitM;
		hitE = (raddr == eAddr) && (tuse < eT);
		hitM = (raddr == mAddr) && (tuse < mT);
		return (raddr != 5'd0) && (hitE || hitM);
	endfunction

	// Nearest in-flight writer wins
	function automatic logic [1:0] fwdSel(
		input logic [4:0] raddr,
		input logic [4:0] eAddr,
		input logic [4:0] mAddr,
		input logic [4:0] wAddr
	);
		logic [1:0] sel;
		if (raddr == 5'd0)
			sel = FWD_RF; // $0 is never forwarded
		else if (raddr == eAddr)
			sel = FWD_E;
		else if (raddr == mAddr)
			sel = FWD_M;
		else if (raddr == wAddr)
			sel = FWD_W;
		else
			sel = FWD_RF;
		return sel;
	endfunction

	always_comb
	begin
		stallRs = needStall(at.raddr0, at.tuse0, eWaddr, eTnew, mWaddr, mTnew);
		stallRt = needStall(at.raddr1, at.tuse1, eWaddr, eTnew, mWaddr, mTnew);
		fwdRs   = fwdSel(at.raddr0, eWaddr, mWaddr, wWaddr);
		fwdRt   = fwdSel(at.raddr1, eWaddr, mWaddr, wWaddr);
	end

	assign stall = stallRs | stallRt; // Either operand holds D

endmodule

// File: design/hazardUnit.sv
`timescale 1ns/1ps

module hazardUnit (
	input  logic        clk,
	input  logic        rst,
	input  logic [31:0] instr, // D-stage word, held while stall is high
	output logic        stall,
	output logic [1:0]  fwdRs,
	output logic [1:0]  fwdRt
);
	import hazardPkg::*;

	instrWord_t instrW;
	logic [3:0] cls;
	logic [4:0] eWaddr;
	logic [2:0] eTnew;
	logic [4:0] mWaddr;
	logic [2:0] mTnew;
	logic [4:0] wWaddr;

	atIf dAt (); // Needs of the D instruction

	assign instrW = instr;

	////////////////////////////////////////////////////////////////////
	// D stage decode
	////////////////////////////////////////////////////////////////////
	instrDecode i_instrDecode (
		.instr (instrW),
		.cls   (cls)
	);

	atCalc i_atCalc (
		.cls   (cls),
		.instr (instrW),
		.at    (dAt.producer)
	);

	////////////////////////////////////////////////////////////////////
	// In-flight producers and compare
	////////////////////////////////////////////////////////////////////
	atPipe i_atPipe (
		.clk    (clk),
		.rst    (rst),
		.stall  (stall), // Bubble into E
		.at     (dAt.consumer),
		.eWaddr (eWaddr),
		.eTnew  (eTnew),
		.mWaddr (mWaddr),
		.mTnew  (mTnew),
		.wWaddr (wWaddr)
	);

	stallCtrl i_stallCtrl (
		.at     (dAt.consumer),
		.eWaddr (eWaddr),
		.eTnew  (eTnew),
		.mWaddr (mWaddr),
		.mTnew  (mTnew),
		.wWaddr (wWaddr),
		.stall  (stall),
		.fwdRs  (fwdRs),
		.fwdRt  (fwdRt)
	);

endmodule

// File: testbench/hazardUnitTb.sv
`timescale 1ns/1ps

module hazardUnitTb;
	import hazardPkg::*;

	localparam int RESET_CYCLES = 10;
	localparam int N_RANDOM     = 1500;
	localparam int N_DIRECTED   = 37;  // Directed issues including drains
	// Each issue waits at most two stall cycles
	localparam int MAX_CYCLES   = RESET_CYCLES + (N_DIRECTED + N_RANDOM) * 3 + 20;
	localparam logic [31:0] SEED = 32'h919e86f1;

	// Instruction kinds the generator can emit
	localparam int K_NOP    = 0;
	localparam int K_ALUR   = 1;
	localparam int K_ALUI   = 2;
	localparam int K_LOAD   = 3;
	localparam int K_STORE  = 4;
	localparam int K_BR1    = 5;
	localparam int K_BR2    = 6;
	localparam int K_LUI    = 7;
	localparam int K_JAL    = 8;
	localparam int K_JR     = 9;
	localparam int K_J      = 10;
	localparam int K_JALR   = 11;
	localparam int K_MTMD   = 12;
	localparam int K_MULDIV = 13;
	localparam int K_MFMD   = 14;
	localparam int NUM_KINDS = 15;

	// Operand deadlines and result latencies in stages after D
	localparam logic [2:0] U_D  = 3'd0;
	localparam logic [2:0] U_E  = 3'd1;
	localparam logic [2:0] U_M  = 3'd2;
	localparam logic [2:0] U_NO = 3'd7;
	localparam logic [2:0] N_NO   = 3'd0;
	localparam logic [2:0] N_LINK = 3'd1;
	localparam logic [2:0] N_ALU  = 3'd2;
	localparam logic [2:0] N_LOAD = 3'd3;

	typedef struct packed {
		logic [31:0] word;
		logic [4:0]  ra0;
		logic [2:0]  tu0;
		logic [4:0]  ra1;
		logic [2:0]  tu1;
		logic [4:0]  wa;
		logic [2:0]  tn;
	} instrReq_t;

	logic        clk = 1'b0;
	logic        rst;
	logic [31:0] instr;
	logic        stall;
	logic [1:0]  fwdRs;
	logic [1:0]  fwdRt;

	instrReq_t  cur;      // What D holds as the generator built it
	logic [4:0] stW [0:2]; // Model write addresses for E M W
	logic [2:0] stT [0:1]; // Model remaining Tnew for E M
	logic       expStall;
	logic [1:0] expRs;
	logic [1:0] expRt;

	int cycles = 0;
	int cycleChecks = 0;
	int dirChecks = 0;
	int errStall = 0;
	int errRs = 0;
	int errRt = 0;
	int errDir = 0;

	hazardUnit i_dut (
		.clk   (clk),
		.rst   (rst),
		.instr (instr),
		.stall (stall),
		.fwdRs (fwdRs),
		.fwdRt (fwdRt)
	);

	always #50 clk = ~clk; // 100 ns period

	//////////////////////////////////////////////////////////////////////
	// Instruction builder
	//////////////////////////////////////////////////////////////////////
	function automatic instrReq_t needs(input logic [31:0] w, input logic [4:0] ra0,
		input logic [2:0] tu0, input logic [4:0] ra1, input logic [2:0] tu1,
		input logic [4:0] wa, input logic [2:0] tn);
		instrReq_t q;
		q.word = w;
		q.ra0  = ra0;
		q.tu0  = tu0;
		q.ra1  = ra1;
		q.tu1  = tu1;
		q.wa   = wa;
		q.tn   = tn;
		return q;
	endfunction

	// a is the destination, b and c the sources
	function automatic instrReq_t build(input int k, input logic [4:0] a,
		input logic [4:0] b, input logic [4:0] c);
		instrReq_t q;
		case (k)
			K_ALUR:   q = needs({OP_SPECIAL, b, c, a, 5'd0, FN_ADDU}, b, U_E, c, U_E, a, N_ALU);
			K_ALUI:   q = needs({OP_ADDIU, b, a, 16'h0010}, b, U_E, 5'd0, U_NO, a, N_ALU);
			K_LOAD:   q = needs({OP_LW, b, a, 16'h0010}, b, U_E, 5'd0, U_NO, a, N_LOAD);
			K_STORE:  q = needs({OP_SW, b, c, 16'h0010}, b, U_E, c, U_M, 5'd0, N_NO);
			K_BR1:    q = needs({OP_REGIMM, b, RT_BGEZ, 16'h0004}, b, U_D, 5'd0, U_NO, 5'd0, N_NO);
			K_BR2:    q = needs({OP_BEQ, b, c, 16'h0004}, b, U_D, c, U_D, 5'd0, N_NO);
			K_LUI:    q = needs({OP_LUI, 5'd0, a, 16'h1234}, 5'd0, U_NO, 5'd0, U_NO, a, N_LINK);
			K_JAL:    q = needs({OP_JAL, 26'h40}, 5'd0, U_NO, 5'd0, U_NO, 5'd31, N_LINK); // Links $31
			K_JR:     q = needs({OP_SPECIAL, b, 15'd0, FN_JR}, b, U_D, 5'd0, U_NO, 5'd0, N_NO);
			K_J:      q = needs({OP_J, b, c, 16'h0040}, 5'd0, U_NO, 5'd0, U_NO, 5'd0, N_NO);
			K_JALR:   q = needs({OP_SPECIAL, b, 5'd0, a, 5'd0, FN_JALR}, b, U_D, 5'd0, U_NO, a, N_LINK);
			K_MTMD:   q = needs({OP_SPECIAL, b, 15'd0, FN_MTHI}, b, U_E, 5'd0, U_NO, 5'd0, N_NO);
			K_MULDIV: q = needs({OP_SPECIAL, b, c, 10'd0, FN_MULT}, b, U_E, c, U_E, 5'd0, N_NO);
			K_MFMD:   q = needs({OP_SPECIAL, 10'd0, a, 5'd0, FN_MFLO}, 5'd0, U_NO, 5'd0, U_NO, a, N_ALU);
			default:  q = needs(32'd0, 5'd0, U_NO, 5'd0, U_NO, 5'd0, N_NO); // nop
		endcase
		return q;
	endfunction

	//////////////////////////////////////////////////////////////////////
	// Reference model of the in-flight producers
	//////////////////////////////////////////////////////////////////////
	function automatic logic hazard(input logic [4:0] ra, input logic [2:0] tu);
		logic hit;
		hit = 1'b0;
		for (int x = 0; x < 2; x++)
			if (ra != 5'd0 && stW[x] == ra && tu < stT[x])
				hit = 1'b1; // Producer too late for this operand
		return hit;
	endfunction

	function automatic logic [1:0] nearestWriter(input logic [4:0] ra);
		logic [1:0] sel;
		sel = FWD_RF;
		for (int x = 2; x >= 0; x--) // Far to near so the nearest overwrites
			if (ra != 5'd0 && stW[x] == ra)
				sel = 2'(x + 1);
		return sel;
	endfunction

	always_comb
	begin
		expStall = hazard(cur.ra0, cur.tu0) | hazard(cur.ra1, cur.tu1);
		expRs    = nearestWriter(cur.ra0);
		expRt    = nearestWriter(cur.ra1);
	end

	always @(posedge clk)
	begin
		if (rst)
		begin
			for (int x = 0; x < 3; x++)
				stW[x] <= 5'd0;
			stT[0] <= 3'd0;
			stT[1] <= 3'd0;
		end
		else
		begin
			stW[2] <= stW[1];
			stW[1] <= stW[0];
			stT[1] <= (stT[0] == 3'd0) ? 3'd0 : stT[0] - 3'd1;
			stW[0] <= expStall ? 5'd0 : cur.wa; // Bubble while D waits
			stT[0] <= (expStall || cur.tn == 3'd0) ? 3'd0 : cur.tn - 3'd1;
		end
	end

	//////////////////////////////////////////////////////////////////////
	// Per-cycle checks taken mid-cycle where outputs are settled
	//////////////////////////////////////////////////////////////////////
	assert property (@(negedge clk) disable iff (rst) stall == expStall)
	else
	begin
		errStall++;
		$display("ERROR %0t stall got %b exp %b", $time, stall, expStall);
	end

	assert property (@(negedge clk) disable iff (rst) fwdRs == expRs)
	else
	begin
		errRs++;
		$display("ERROR %0t fwdRs got %0d exp %0d", $time, fwdRs, expRs);
	end

	assert property (@(negedge clk) disable iff (rst) fwdRt == expRt)
	else
	begin
		errRt++;
		$display("ERROR %0t fwdRt got %0d exp %0d", $time, fwdRt, expRt);
	end

	always @(negedge clk)
		if (!rst)
			cycleChecks++;

	//////////////////////////////////////////////////////////////////////
	// Stimulus tasks
	//////////////////////////////////////////////////////////////////////
	// Holds the word in D until it issues; entered just after a rising edge
	task automatic sendInstr(input instrReq_t q, output int stalls,
		output logic [1:0] rsSel, output logic [1:0] rtSel);
		logic held;
		instr  = q.word;
		cur    = q;
		stalls = 0;
		held   = 1'b1;
		while (held)
		begin
			@(negedge clk);
			held  = stall;
			rsSel = fwdRs; // Last sample is the issue cycle
			rtSel = fwdRt;
			if (held)
				stalls++;
			@(posedge clk);
			#1;
		end
	endtask

	task automatic expectIssue(input instrReq_t q, input int expStalls,
		input logic [1:0] expRsSel, input logic [1:0] expRtSel);
		int stalls;
		logic [1:0] rsSel;
		logic [1:0] rtSel;
		sendInstr(q, stalls, rsSel, rtSel);
		dirChecks++;
		assert (stalls == expStalls)
		else
		begin
			errDir++;
			$display("ERROR %0t stall cycles got %0d exp %0d", $time, stalls, expStalls);
		end
		assert (rsSel == expRsSel)
		else
		begin
			errDir++;
			$display("ERROR %0t fwdRs got %0d exp %0d", $time, rsSel, expRsSel);
		end
		assert (rtSel == expRtSel)
		else
		begin
			errDir++;
			$display("ERROR %0t fwdRt got %0d exp %0d", $time, rtSel, expRtSel);
		end
	endtask

	task automatic drain();
		for (int n = 0; n < 3; n++)
			expectIssue(build(K_NOP, 5'd0, 5'd0, 5'd0), 0, FWD_RF, FWD_RF);
	endtask

	//////////////////////////////////////////////////////////////////////
	// Main sequence
	//////////////////////////////////////////////////////////////////////
	initial
	begin
		int k;
		int stalls;
		int total;
		logic [1:0] rsSel;
		logic [1:0] rtSel;
		void'($urandom(SEED));
		rst   = 1'b1;
		instr = 32'd0;
		cur   = build(K_NOP, 5'd0, 5'd0, 5'd0);
		repeat (RESET_CYCLES) @(posedge clk);
		#1;
		rst = 1'b0;
		// Nothing in flight after reset, even for D-stage readers
		expectIssue(build(K_BR2, 5'd0, 5'd1, 5'd2), 0, FWD_RF, FWD_RF);

		// Load-use gives one bubble then M
		expectIssue(build(K_LOAD, 5'd1, 5'd2, 5'd0), 0, FWD_RF, FWD_RF);
		expectIssue(build(K_ALUR, 5'd3, 5'd1, 5'd4), 1, FWD_M, FWD_RF);
		drain();
		// Branch compares in D
		expectIssue(build(K_ALUR, 5'd1, 5'd2, 5'd3), 0, FWD_RF, FWD_RF);
		expectIssue(build(K_BR2, 5'd0, 5'd1, 5'd2), 1, FWD_M, FWD_RF);
		drain();
		// Store data late enough for E
		expectIssue(build(K_ALUR, 5'd5, 5'd6, 5'd7), 0, FWD_RF, FWD_RF);
		expectIssue(build(K_STORE, 5'd0, 5'd6, 5'd5), 0, FWD_RF, FWD_E);
		drain();
		// $0 writers and operand-free instructions
		expectIssue(build(K_ALUR, 5'd0, 5'd1, 5'd2), 0, FWD_RF, FWD_RF);
		expectIssue(build(K_ALUR, 5'd3, 5'd0, 5'd0), 0, FWD_RF, FWD_RF);
		expectIssue(build(K_LOAD, 5'd0, 5'd2, 5'd0), 0, FWD_RF, FWD_RF);
		expectIssue(build(K_BR2, 5'd0, 5'd0, 5'd0), 0, FWD_RF, FWD_RF);
		expectIssue(build(K_LOAD, 5'd1, 5'd2, 5'd0), 0, FWD_RF, FWD_RF);
		expectIssue(build(K_LUI, 5'd1, 5'd0, 5'd0), 0, FWD_RF, FWD_RF);
		expectIssue(build(K_J, 5'd0, 5'd1, 5'd1), 0, FWD_RF, FWD_RF); // Target bits alias $1
		expectIssue(build(K_MFMD, 5'd1, 5'd0, 5'd0), 0, FWD_RF, FWD_RF);
		drain();
		// Link value is ready out of E
		expectIssue(build(K_JAL, 5'd0, 5'd0, 5'd0), 0, FWD_RF, FWD_RF);
		expectIssue(build(K_JR, 5'd0, 5'd31, 5'd0), 0, FWD_E, FWD_RF);
		drain();
		// Load into a branch gives two bubbles then W
		expectIssue(build(K_LOAD, 5'd2, 5'd3, 5'd0), 0, FWD_RF, FWD_RF);
		expectIssue(build(K_BR1, 5'd0, 5'd2, 5'd0), 2, FWD_W, FWD_RF);
		drain();

		// Random stream over a small register set for dense hazards
		for (int i = 0; i < N_RANDOM; i++)
		begin
			k = int'($urandom % NUM_KINDS);
			sendInstr(build(k, 5'($urandom % 4), 5'($urandom % 4), 5'($urandom % 4)),
				stalls, rsSel, rtSel);
		end

		total = errStall + errRs + errRt + errDir;
		$display("Cycle checks %0d directed %0d, errors stall %0d rs %0d rt %0d dir %0d",
			cycleChecks, dirChecks, errStall, errRs, errRt, errDir);
		if (total == 0)
			$display("All checks passed");
		else
			$display("Checks failed");
		$finish;
	end

	// Watchdog on the whole run
	initial
	begin
		while (cycles < MAX_CYCLES)
		begin
			@(posedge clk);
			cycles++;
		end
		$display("Timeout, run did not finish within %0d cycles", MAX_CYCLES);
		$display("Checks failed");
		$finish;
	end

endmodule

// File: src.f
design/hazardPkg.sv
design/atIf.sv
design/instrDecode.sv
design/atCalc.sv
design/atPipe.sv
design/stallCtrl.sv
design/hazardUnit.sv
testbench/hazardUnitTb.sv

// File: Makefile
VERILATOR = verilator
VFLAGS    = --binary --assert
TOP       = hazardUnitTb
FILELIST  = src.f
OBJDIR    = obj_dir

SIM  = $(OBJDIR)/V$(TOP)
SRCS = $(shell cat $(FILELIST))

.PHONY: all run clean

all: run

# Rebuilt only when a source or the file list changes
$(SIM): $(SRCS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir $(OBJDIR)

run: $(SIM)
	@out="$$(./$(SIM))"; echo "$$out"; echo "$$out" | grep -qx "All checks passed"

clean:
	rm -rf $(OBJDIR)
